// ==== Makefile ====
SIM       := verilator
TOP       := tbDataPath
FILELIST  := files.f
SIMFLAGS  := --binary --timing --assert --timescale 1ns/1ps
LINTFLAGS := --lint-only --timing --assert --timescale 1ns/1ps -Wall
OBJDIR    := obj_dir
LOG       := sim.log
PASSMSG   := Verification passed

.PHONY: all build run lint clean

all: run

build:
	$(SIM) $(SIMFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(OBJDIR)

run: build
	./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASSMSG)" $(LOG) || { echo "Simulation did not pass, see $(LOG)"; exit 1; }

lint:
	$(SIM) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== design/alu.sv ====
module alu import cpuPkg::*; (
    input  aluOpT                  aluOp,
    input  logic [DataWidth-1:0]   a,       // From Y
    input  logic [DataWidth-1:0]   b,       // From the bus
    output logic [2*DataWidth-1:0] result   // High half to Z high
);

    localparam int ShWidth = $clog2(DataWidth);

    logic [ShWidth-1:0]     shAmt;
    logic [2*DataWidth-1:0] product;
    logic [DataWidth-1:0]   quotient;
    logic [DataWidth-1:0]   remainder;
    logic                   divOverflow;

    assign shAmt = b[ShWidth-1:0];

    // Low 64 bits of the product of sign-extended operands
    assign product = {{DataWidth{a[DataWidth-1]}}, a} * {{DataWidth{b[DataWidth-1]}}, b};

    // Most negative over minus one would trap, wraps instead
    assign divOverflow = (a == {1'b1, {(DataWidth - 1){1'b0}}}) && (b == '1);

    always_comb begin
        if (b == '0) begin
            quotient  = '0;
            remainder = '0;
        end else if (divOverflow) begin
            quotient  = a;
            remainder = '0;
        end else begin
            quotient  = DataWidth'($signed(a) / $signed(b));
            remainder = DataWidth'($signed(a) % $signed(b));
        end
    end

    always_comb begin
        result = '0;
        case (aluOp)
            add:   result[DataWidth-1:0] = a + b;
            sub:   result[DataWidth-1:0] = a - b;
            andOp: result[DataWidth-1:0] = a & b;
            orOp:  result[DataWidth-1:0] = a | b;
            shr:   result[DataWidth-1:0] = a >> shAmt;
            shra:  result[DataWidth-1:0] = DataWidth'($signed(a) >>> shAmt);
            shl:   result[DataWidth-1:0] = a << shAmt;
            ror: begin
                result[DataWidth-1:0] = (a >> shAmt) | (a << (DataWidth - int'(shAmt)));
            end
            rol: begin
                result[DataWidth-1:0] = (a << shAmt) | (a >> (DataWidth - int'(shAmt)));
            end
            neg:   result[DataWidth-1:0] = -b;   // Unary ops act on the bus operand
            notOp: result[DataWidth-1:0] = ~b;
            mul:   result = product;
            div:   result = {remainder, quotient};
            default: result = '0;
        endcase
    end

endmodule

// ==== design/busMux.sv ====
module busMux import cpuPkg::*, busPkg::*; (
    input  logic                 pcOut,
    input  logic                 zHighOut,
    input  logic                 zLowOut,
    input  logic                 hiOut,
    input  logic                 loOut,
    input  logic                 mdrOut,
    input  logic                 inPortOut,
    input  logic                 cOut,
    input  logic                 regSel,     // Some register drives out
    input  logic [DataWidth-1:0] regData,
    input  logic [DataWidth-1:0] pc,
    input  logic [DataWidth-1:0] mdr,
    input  logic [DataWidth-1:0] zHigh,
    input  logic [DataWidth-1:0] zLow,
    input  logic [DataWidth-1:0] hi,
    input  logic [DataWidth-1:0] lo,
    input  logic [DataWidth-1:0] inPort,
    input  logic [DataWidth-1:0] cValue,
    output logic [DataWidth-1:0] busData
);

    busSrcT busSrc;

    // Strobe encoder, only one should be active
    always_comb begin
        if      (regSel)    busSrc = srcReg;
        else if (pcOut)     busSrc = srcPc;
        else if (mdrOut)    busSrc = srcMdr;
        else if (zHighOut)  busSrc = srcZHigh;
        else if (zLowOut)   busSrc = srcZLow;
        else if (hiOut)     busSrc = srcHi;
        else if (loOut)     busSrc = srcLo;
        else if (inPortOut) busSrc = srcInPort;
        else if (cOut)      busSrc = srcC;
        else                busSrc = srcNone;
    end

    always_comb begin
        case (busSrc)
            srcReg:    busData = regData;
            srcPc:     busData = pc;
            srcMdr:    busData = mdr;
            srcZHigh:  busData = zHigh;
            srcZLow:   busData = zLow;
            srcHi:     busData = hi;
            srcLo:     busData = lo;
            srcInPort: busData = inPort;
            srcC:      busData = cValue;
            default:   busData = '0;  // Idle bus reads zero
        endcase
    end

endmodule

// ==== design/busPkg.sv ====
package busPkg;

    // General purpose registers R0 to R15
    localparam int NumRegs = 16;

    // Which unit drives the shared bus this cycle
    typedef enum logic [4:0] {
        srcNone   = 5'd0,
        srcReg    = 5'd1,
        srcPc     = 5'd2,
        srcMdr    = 5'd3,
        srcZHigh  = 5'd4,
        srcZLow   = 5'd5,
        srcHi     = 5'd6,
        srcLo     = 5'd7,
        srcInPort = 5'd8,
        srcC      = 5'd9
    } busSrcT;

endpackage

// ==== design/conFf.sv ====
module conFf import cpuPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 conIn,
    input  logic [1:0]           cond,      // IR[20:19]
    input  logic [DataWidth-1:0] busData,
    output logic                 conOut
);

    condT condType;
    logic isZero;
    logic condMet;

    assign condType = condT'(cond);
    assign isZero   = (busData == '0);

    // Branch rule on the register value on the bus
    always_comb begin
        case (condType)
            zr:      condMet = isZero;
            nz:      condMet = !isZero;
            pl:      condMet = !busData[DataWidth-1];
            mi:      condMet = busData[DataWidth-1];
            default: condMet = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            conOut <= 1'b0;
        end else if (conIn) begin
            conOut <= condMet;
        end
    end

endmodule

// ==== design/cpuPkg.sv ====
package cpuPkg;

    // Bus and register width
    localparam int DataWidth = 32;

    // IR field positions
    localparam int OpcodeMsb = 31;
    localparam int OpcodeLsb = 27;
    localparam int RaMsb     = 26;
    localparam int RaLsb     = 23;
    localparam int RbMsb     = 22;
    localparam int RbLsb     = 19;
    localparam int RcMsb     = 18;
    localparam int RcLsb     = 15;
    localparam int CMsb      = 18;
    localparam int CLsb      = 0;
    localparam int CondMsb   = 20;  // Branch type sits inside the Rb field
    localparam int CondLsb   = 19;

    // ALU operations, coded as the opcode field
    typedef enum logic [4:0] {
        add   = 5'b00011,
        sub   = 5'b00100,
        andOp = 5'b00101,
        orOp  = 5'b00110,
        ror   = 5'b00111,
        rol   = 5'b01000,
        shr   = 5'b01001,
        shra  = 5'b01010,
        shl   = 5'b01011,
        div   = 5'b01111,
        mul   = 5'b10000,
        neg   = 5'b10001,
        notOp = 5'b10010
    } aluOpT;

    // Branch conditions from IR[20:19]
    typedef enum logic [1:0] {
        zr = 2'b00,  // Zero
        nz = 2'b01,  // Nonzero
        pl = 2'b10,  // Positive or zero
        mi = 2'b11   // Negative
    } condT;

endpackage

// ==== design/dataPath.sv ====
module dataPath import cpuPkg::*, busPkg::*; #(
    parameter int                   MemDepth = 512,
    parameter logic [DataWidth-1:0] PcReset  = '0
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 pcIn,
    input  logic                 irIn,
    input  logic                 yIn,
    input  logic                 zIn,
    input  logic                 hiIn,
    input  logic                 loIn,
    input  logic                 marIn,
    input  logic                 mdrIn,
    input  logic                 outPortIn,
    input  logic                 incPc,
    input  logic                 pcOut,
    input  logic                 zHighOut,
    input  logic                 zLowOut,
    input  logic                 hiOut,
    input  logic                 loOut,
    input  logic                 mdrOut,
    input  logic                 inPortOut,
    input  logic                 cOut,
    input  logic                 gra,
    input  logic                 grb,
    input  logic                 grc,
    input  logic                 rIn,
    input  logic                 rOut,
    input  logic                 baOut,
    input  logic                 memRead,
    input  logic                 memWrite,
    input  logic                 conIn,
    input  aluOpT                aluOp,
    input  logic [DataWidth-1:0] inPortData,
    output logic [DataWidth-1:0] busData,
    output logic [DataWidth-1:0] outPortData,
    output logic                 conOut,
    output logic [DataWidth-1:0] pcValue
);

    localparam int AddrWidth = $clog2(MemDepth);

    logic [DataWidth-1:0]   pc, ir, y, zHigh, zLow, hi, lo, mar, mdr, outPort;
    logic [DataWidth-1:0]   mem [MemDepth];
    logic [DataWidth-1:0]   regData;
    logic [DataWidth-1:0]   cValue;
    logic [NumRegs-1:0]     regLoad;
    logic [NumRegs-1:0]     regOut;
    logic [2*DataWidth-1:0] zResult;
    logic [2*DataWidth-1:0] zNext;
    logic [AddrWidth-1:0]   memAddr;

    assign memAddr = mar[AddrWidth-1:0];

    // PC increment bypasses the ALU during fetch
    assign zNext = incPc ? {{DataWidth{1'b0}}, pc + 1'b1} : zResult;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc      <= PcReset;
            ir      <= '0;
            y       <= '0;
            zHigh   <= '0;
            zLow    <= '0;
            hi      <= '0;
            lo      <= '0;
            mar     <= '0;
            mdr     <= '0;
            outPort <= '0;
        end else begin
            if (pcIn)      pc      <= busData;
            if (irIn)      ir      <= busData;
            if (yIn)       y       <= busData;
            if (hiIn)      hi      <= busData;
            if (loIn)      lo      <= busData;
            if (marIn)     mar     <= busData;
            if (outPortIn) outPort <= busData;
            if (zIn) begin
                zHigh <= zNext[2*DataWidth-1:DataWidth];
                zLow  <= zNext[DataWidth-1:0];
            end
            if (mdrIn) begin
                mdr <= memRead ? mem[memAddr] : busData;  // Memory or bus
            end
        end
    end

    always_ff @(posedge clk) begin
        if (memWrite) begin
            mem[memAddr] <= mdr;
        end
    end

    assign outPortData = outPort;
    assign pcValue     = pc;

    selectEncode u_selectEncode (
        .ir      (ir),
        .gra     (gra),
        .grb     (grb),
        .grc     (grc),
        .rIn     (rIn),
        .rOut    (rOut),
        .baOut   (baOut),
        .regLoad (regLoad),
        .regOut  (regOut),
        .cValue  (cValue)
    );

    regFile u_regFile (
        .clk     (clk),
        .rstN    (rstN),
        .busData (busData),
        .regLoad (regLoad),
        .regOut  (regOut),
        .baOut   (baOut),
        .regData (regData)
    );

    busMux u_busMux (
        .pcOut     (pcOut),
        .zHighOut  (zHighOut),
        .zLowOut   (zLowOut),
        .hiOut     (hiOut),
        .loOut     (loOut),
        .mdrOut    (mdrOut),
        .inPortOut (inPortOut),
        .cOut      (cOut),
        .regSel    (|regOut),
        .regData   (regData),
        .pc        (pc),
        .mdr       (mdr),
        .zHigh     (zHigh),
        .zLow      (zLow),
        .hi        (hi),
        .lo        (lo),
        .inPort    (inPortData),
        .cValue    (cValue),
        .busData   (busData)
    );

    alu u_alu (
        .aluOp  (aluOp),
        .a      (y),
        .b      (busData),
        .result (zResult)
    );

    conFf u_conFf (
        .clk     (clk),
        .rstN    (rstN),
        .conIn   (conIn),
        .cond    (ir[CondMsb:CondLsb]),
        .busData (busData),
        .conOut  (conOut)
    );

endmodule

// ==== design/regFile.sv ====
module regFile import cpuPkg::*, busPkg::*; (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic [DataWidth-1:0] busData,
    input  logic [NumRegs-1:0]   regLoad,
    input  logic [NumRegs-1:0]   regOut,
    input  logic                 baOut,
    output logic [DataWidth-1:0] regData
);

    logic [DataWidth-1:0] regs [NumRegs];

    // Each register loads from the bus on its own enable
    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 0; i < NumRegs; i++) begin
                regs[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NumRegs; i++) begin
                if (regLoad[i]) begin
                    regs[i] <= busData;
                end
            end
        end
    end

    // One-hot read, OR of the selected registers
    always_comb begin
        regData = '0;
        for (int i = 0; i < NumRegs; i++) begin
            if (regOut[i]) begin
                regData = regData | regs[i];
            end
        end
        // Base addressing treats R0 as zero
        if (baOut && regOut[0]) begin
            regData = '0;
        end
    end

endmodule

// ==== design/selectEncode.sv ====
module selectEncode import cpuPkg::*, busPkg::*; (
    input  logic [DataWidth-1:0] ir,
    input  logic                 gra,
    input  logic                 grb,
    input  logic                 grc,
    input  logic                 rIn,
    input  logic                 rOut,
    input  logic                 baOut,
    output logic [NumRegs-1:0]   regLoad,
    output logic [NumRegs-1:0]   regOut,
    output logic [DataWidth-1:0] cValue
);

    localparam int FieldWidth = $clog2(NumRegs);

    logic [FieldWidth-1:0] regField;
    logic                  fieldValid;
    logic [NumRegs-1:0]    regDecoded;

    // Pick the register field named by the step
    always_comb begin
        fieldValid = gra | grb | grc;
        if (gra) begin
            regField = ir[RaMsb:RaLsb];
        end else if (grb) begin
            regField = ir[RbMsb:RbLsb];
        end else if (grc) begin
            regField = ir[RcMsb:RcLsb];
        end else begin
            regField = '0;
        end
    end

    // 4-to-16 decode
    always_comb begin
        regDecoded = '0;
        if (fieldValid) begin
            regDecoded[regField] = 1'b1;
        end
    end

    assign regLoad = regDecoded & {NumRegs{rIn}};
    assign regOut  = regDecoded & {NumRegs{rOut | baOut}};

    // Sign extend the 19-bit constant
    assign cValue = {{(DataWidth - CMsb - 1){ir[CMsb]}}, ir[CMsb:CLsb]};

endmodule

// ==== files.f ====
design/cpuPkg.sv
design/busPkg.sv
design/regFile.sv
design/selectEncode.sv
design/busMux.sv
design/alu.sv
design/conFf.sv
design/dataPath.sv
test/tbClock.sv
test/dataPath_asserts.sv
test/tbDataPath.sv

// ==== test/dataPath_asserts.sv ====
module dataPath_asserts import cpuPkg::*; (
    input logic                 clk,
    input logic                 rstN,
    input logic                 pcIn,
    input logic                 incPc,
    input logic                 conIn,
    input logic                 pcOut,
    input logic                 zHighOut,
    input logic                 zLowOut,
    input logic                 hiOut,
    input logic                 loOut,
    input logic                 mdrOut,
    input logic                 inPortOut,
    input logic                 cOut,
    input logic                 rOut,
    input logic                 baOut,
    input logic [DataWidth-1:0] pcValue,
    input logic                 conOut
);
    timeunit 1ns;
    timeprecision 1ps;

    int unsigned failCount = 0;  // Read by the testbench

    // One bus source per cycle
    assert property (@(posedge clk) disable iff (!rstN)
        $onehot0({pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut, inPortOut, cOut, rOut | baOut}))
    else begin
        failCount++;
        $error("More than one bus source enabled in the same cycle");
    end

    assert property (@(posedge clk) disable iff (!rstN)
        (!$past(pcIn) && !$past(incPc)) |-> $stable(pcValue))
    else begin
        failCount++;
        $error("PC changed without pcIn or incPc");
    end

    // CON moves only after a conIn step
    assert property (@(posedge clk) disable iff (!rstN)
        !$past(conIn) |-> $stable(conOut))
    else begin
        failCount++;
        $error("conOut changed without conIn in the previous cycle");
    end

endmodule

bind dataPath dataPath_asserts u_asserts (
    .clk(clk), .rstN(rstN), .pcIn(pcIn), .incPc(incPc), .conIn(conIn),
    .pcOut(pcOut), .zHighOut(zHighOut), .zLowOut(zLowOut), .hiOut(hiOut),
    .loOut(loOut), .mdrOut(mdrOut), .inPortOut(inPortOut), .cOut(cOut),
    .rOut(rOut), .baOut(baOut), .pcValue(pcValue), .conOut(conOut)
);

// ==== test/tbClock.sv ====
module tbClock #(
    parameter int Period      = 40,
    parameter int ResetCycles = 3
) (
    output logic clk,
    output logic rstN
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
        forever #(Period / 2) clk = ~clk;
    end

    // Released on a falling edge, after three rising edges
    initial begin
        rstN = 1'b0;
        #(Period * ResetCycles) rstN = 1'b1;
    end

endmodule

// ==== test/tbDataPath.sv ====
module tbDataPath import cpuPkg::*; ();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int                   MemDepth      = 512;
    localparam logic [DataWidth-1:0] PcReset       = '0;
    localparam int                   TimeoutCycles = 4000;  // Tests take about 800 cycles
    localparam int                   SampleDelay   = 10;    // Quarter period after rising edge
    localparam logic [4:0]           BrOpcode      = 5'b10011;
    localparam int                   ChkOut        = 0;
    localparam int                   ChkPc         = 1;
    localparam int                   ChkCon        = 2;
    localparam int                   ChkBus        = 3;

    logic clk, rstN;
    logic pcIn, irIn, yIn, zIn, hiIn, loIn, marIn, mdrIn, outPortIn, incPc;
    logic pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut, inPortOut, cOut;
    logic gra, grb, grc, rIn, rOut, baOut, memRead, memWrite, conIn;
    aluOpT aluOp;
    logic [DataWidth-1:0] inPortData, busData, outPortData, pcValue;
    logic conOut;

    logic [31:0] rngState = 32'h95d;
    int          kindQ [$];   // Pending checks, evaluated after the next rising edge
    logic [31:0] expQ [$];
    string       nameQ [$];
    int          cycleCount = 0;

    tbClock #(.Period(40), .ResetCycles(3)) u_clock (.clk(clk), .rstN(rstN));

    dataPath #(.MemDepth(MemDepth), .PcReset(PcReset)) i_dut (.*);

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        return s ^ (s << 5);
    endfunction

    function automatic logic [31:0] nextRandom();
        rngState = xorshift(rngState);
        return rngState;
    endfunction

    // Expected {Z high, Z low} for one ALU operation
    function automatic logic [63:0] refModel(input aluOpT op, input logic [31:0] a,
                                             input logic [31:0] b);
        longint      sa;
        longint      sb;
        longint      q;
        longint      rm;
        logic [63:0] t;
        logic [63:0] u;
        int          n;
        sa = longint'($signed(a));
        sb = longint'($signed(b));
        n  = int'(b[4:0]);
        case (op)
            add:   return {32'h0, a + b};
            sub:   return {32'h0, a - b};
            andOp: return {32'h0, a & b};
            orOp:  return {32'h0, a | b};
            shr:   return {32'h0, a >> n};
            shl:   return {32'h0, a << n};
            neg:   return {32'h0, 32'h0 - b};
            notOp: return {32'h0, ~b};
            shra: begin
                t = {{32{a[31]}}, a} >> n;  // Sign bits shift in from above
                return {32'h0, t[31:0]};
            end
            ror: begin
                t = {a, a} >> n;
                return {32'h0, t[31:0]};
            end
            rol: begin
                t = {a, a} << n;
                return {32'h0, t[63:32]};
            end
            mul:   return sa * sb;
            div: begin
                if (b == 32'h0) return 64'h0;
                q  = sa / sb;
                rm = sa % sb;
                t  = q;
                u  = rm;
                return {u[31:0], t[31:0]};  // Remainder high, quotient low
            end
            default: return 64'h0;
        endcase
    endfunction

    function automatic logic condHolds(input logic [1:0] cond, input logic [31:0] v);
        case (condT'(cond))
            zr:      return v == 32'h0;
            nz:      return v != 32'h0;
            pl:      return !v[31];
            default: return v[31];
        endcase
    endfunction

    function automatic logic [31:0] makeInstr(input logic [4:0] op, input logic [3:0] ra,
                                              input logic [3:0] c2, input logic [18:0] c);
        return {op, ra, c2, c};
    endfunction

    task automatic failRun(input string msg);
        $display("%s", msg);
        $display("Verification failed");
        $fatal(1);
    endtask

    task automatic pushCheck(input int kind, input logic [31:0] expected, input string name);
        kindQ.push_back(kind);
        expQ.push_back(expected);
        nameQ.push_back(name);
    endtask

    // New control step, all strobes low
    task automatic startStep();
        @(negedge clk);
        {pcIn, irIn, yIn, zIn, hiIn, loIn, marIn, mdrIn, outPortIn, incPc} = '0;
        {pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut, inPortOut, cOut} = '0;
        {gra, grb, grc, rIn, rOut, baOut, memRead, memWrite, conIn} = '0;
        aluOp = add;
    endtask

    task automatic loadIr(input logic [31:0] instr);
        startStep();
        inPortData = instr;
        inPortOut  = 1'b1;
        irIn       = 1'b1;
    endtask

    task automatic writeReg(input logic [3:0] r, input logic [31:0] v);
        loadIr(makeInstr(5'h0, r, 4'h0, 19'h0));
        startStep();
        inPortData = v;
        inPortOut  = 1'b1;
        gra        = 1'b1;
        rIn        = 1'b1;
    endtask

    // Register to output port, plain or base-address read
    task automatic readReg(input logic [3:0] r, input logic base, input logic [31:0] expected);
        loadIr(makeInstr(5'h0, r, 4'h0, 19'h0));
        startStep();
        gra       = 1'b1;
        rOut      = !base;
        baOut     = base;
        outPortIn = 1'b1;
        pushCheck(ChkOut, expected, $sformatf("outPortData R%0d base %0d", r, base));
        pushCheck(ChkBus, expected, $sformatf("busData R%0d base %0d", r, base));
    endtask

    task automatic runAlu(input aluOpT op, input logic [31:0] a, input logic [31:0] b);
        logic [63:0] expected;
        expected = refModel(op, a, b);
        startStep();
        inPortData = a;
        inPortOut  = 1'b1;
        yIn        = 1'b1;
        startStep();
        inPortData = b;
        inPortOut  = 1'b1;
        aluOp      = op;
        zIn        = 1'b1;
        startStep();
        zLowOut = 1'b1;
        loIn    = 1'b1;
        startStep();
        zHighOut = 1'b1;
        hiIn     = 1'b1;
        startStep();
        loOut     = 1'b1;
        outPortIn = 1'b1;
        pushCheck(ChkOut, expected[31:0], $sformatf("outPortData LO %s", op.name()));
        startStep();
        hiOut     = 1'b1;
        outPortIn = 1'b1;
        pushCheck(ChkOut, expected[63:32], $sformatf("outPortData HI %s", op.name()));
    endtask

    task automatic writeWord(input logic [31:0] addr, input logic [31:0] data);
        startStep();
        inPortData = addr;
        inPortOut  = 1'b1;
        marIn      = 1'b1;
        startStep();
        inPortData = data;
        inPortOut  = 1'b1;
        mdrIn      = 1'b1;
        startStep();
        memWrite = 1'b1;
    endtask

    task automatic readWord(input logic [31:0] addr, input logic [31:0] expected);
        startStep();
        inPortData = addr;
        inPortOut  = 1'b1;
        marIn      = 1'b1;
        startStep();
        memRead = 1'b1;
        mdrIn   = 1'b1;
        startStep();
        mdrOut    = 1'b1;
        outPortIn = 1'b1;
        pushCheck(ChkOut, expected, $sformatf("outPortData mem[0x%h]", addr));
    endtask

    task automatic checkCondition(input logic [1:0] cond, input logic [3:0] r,
                                  input logic [31:0] v);
        writeReg(r, v);
        loadIr(makeInstr(BrOpcode, r, {2'b00, cond}, 19'h0));
        startStep();
        gra   = 1'b1;
        rOut  = 1'b1;
        conIn = 1'b1;
        pushCheck(ChkCon, {31'h0, condHolds(cond, v)}, $sformatf("conOut cond %0d", cond));
    endtask

    // brmi fetched from memory, steps T0 to T6
    task automatic runBranch(input logic [31:0] pc0, input logic [3:0] r, input logic [31:0] v,
                             input int c);
        logic [31:0] expPc;
        expPc = v[31] ? pc0 + 32'd1 + 32'(c) : pc0 + 32'd1;
        writeWord(pc0, makeInstr(BrOpcode, r, {2'b00, mi}, 19'(c)));
        writeReg(r, v);
        startStep();
        inPortData = pc0;
        inPortOut  = 1'b1;
        pcIn       = 1'b1;
        startStep();  // T0
        pcOut = 1'b1;
        marIn = 1'b1;
        incPc = 1'b1;
        zIn   = 1'b1;
        startStep();  // T1
        zLowOut = 1'b1;
        pcIn    = 1'b1;
        memRead = 1'b1;
        mdrIn   = 1'b1;
        startStep();  // T2
        mdrOut = 1'b1;
        irIn   = 1'b1;
        startStep();  // T3
        gra   = 1'b1;
        rOut  = 1'b1;
        conIn = 1'b1;
        startStep();  // T4
        pcOut = 1'b1;
        yIn   = 1'b1;
        startStep();  // T5
        cOut = 1'b1;
        zIn  = 1'b1;
        startStep();  // T6, taken only when CON is set
        if (conOut) begin
            zLowOut = 1'b1;
            pcIn    = 1'b1;
        end
        pushCheck(ChkPc, expPc, $sformatf("pcValue after brmi R%0d", r));
    endtask

    task automatic testRegisters();
        logic [31:0] vals [16];
        logic [3:0]  r;
        for (int i = 0; i < 16; i++) begin
            vals[i] = nextRandom();
            writeReg(4'(i), vals[i]);
        end
        for (int i = 0; i < 8; i++) begin
            r       = 4'(nextRandom());
            vals[r] = nextRandom();
            writeReg(r, vals[r]);
        end
        for (int i = 0; i < 16; i++) readReg(4'(i), 1'b0, vals[i]);
        readReg(4'h0, 1'b1, 32'h0);
    endtask

    task automatic testAlu();
        aluOpT       ops [13] = '{add, sub, andOp, orOp, shr, shra, shl, ror, rol,
                                  neg, notOp, mul, div};
        logic [31:0] b;
        foreach (ops[i]) begin
            for (int k = 0; k < 6; k++) begin
                b = nextRandom();
                if (ops[i] == div && k % 2 == 1) b = b >>> 24;  // Small divisors too
                runAlu(ops[i], nextRandom(), b);
            end
        end
        runAlu(div, nextRandom(), 32'h0);
        runAlu(div, 32'h8000_0000, 32'hffff_ffff);
    endtask

    task automatic testMemory();
        logic [31:0] shadow [int];
        int          addrs [$];
        logic [31:0] addr;
        for (int i = 0; i < 16; i++) begin
            addr                = nextRandom() % MemDepth;
            shadow[int'(addr)]  = nextRandom();
            addrs.push_back(int'(addr));
            writeWord(addr, shadow[int'(addr)]);
        end
        foreach (addrs[i]) readWord(32'(addrs[i]), shadow[addrs[i]]);
    endtask

    task automatic testConditions();
        logic [31:0] vals [4];
        for (int c = 0; c < 4; c++) begin
            vals[0] = 32'h0;
            vals[1] = nextRandom() & 32'h7fff_ffff;
            vals[2] = nextRandom() | 32'h8000_0000;
            vals[3] = nextRandom();
            foreach (vals[k]) checkCondition(2'(c), 4'(nextRandom()), vals[k]);
        end
    endtask

    task automatic testBranches();
        logic [31:0] v;
        logic [31:0] t;
        for (int k = 0; k < 4; k++) begin
            v = nextRandom();
            v[31] = (k % 2 == 0);  // Alternate taken and not taken
            t = nextRandom();
            runBranch(nextRandom() % MemDepth, 4'(nextRandom()), v, int'(t[6:0]) - 64);
        end
    endtask

    // Compare process, samples a quarter period after the rising edge
    always begin
        int          kind;
        logic [31:0] expected;
        logic [31:0] actual;
        string       name;
        @(posedge clk);
        #SampleDelay;
        while (kindQ.size() > 0) begin
            kind     = kindQ.pop_front();
            expected = expQ.pop_front();
            name     = nameQ.pop_front();
            actual   = (kind == ChkOut) ? outPortData :
                       (kind == ChkPc)  ? pcValue :
                       (kind == ChkBus) ? busData : {31'h0, conOut};
            assert (actual === expected)
            else failRun($sformatf("CHECK FAILED %s: expected 0x%h, got 0x%h",
                                   name, expected, actual));
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= TimeoutCycles) begin
            failRun($sformatf("Timeout: tests did not finish within %0d cycles", TimeoutCycles));
        end else if (i_dut.u_asserts.failCount != 0) begin
            failRun("A bound protocol assertion on the datapath failed");
        end
    end

    initial begin
        inPortData = '0;
        {pcIn, irIn, yIn, zIn, hiIn, loIn, marIn, mdrIn, outPortIn, incPc} = '0;
        {pcOut, zHighOut, zLowOut, hiOut, loOut, mdrOut, inPortOut, cOut} = '0;
        {gra, grb, grc, rIn, rOut, baOut, memRead, memWrite, conIn} = '0;
        aluOp = add;
        wait (rstN === 1'b1);
        startStep();
        pushCheck(ChkOut, 32'h0, "outPortData after reset");
        pushCheck(ChkPc, PcReset, "pcValue after reset");
        pushCheck(ChkCon, 32'h0, "conOut after reset");
        testRegisters();
        testAlu();
        testMemory();
        testConditions();
        testBranches();
        startStep();
        startStep();
        if (kindQ.size() == 0 && i_dut.u_asserts.failCount == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            failRun("Checks left pending or an assertion failed at the end of the run");
        end
    end

endmodule
